/* vlog.f */
design/cache_cfg_pkg.sv
design/mem_bus_pkg.sv
design/sdp_ram.sv
design/dcache_meta.sv
design/dcache_ctrl.sv
design/dcache_top.sv
verif/mem_model.sv
verif/dcache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"
rm -f sim.log

verilator --binary --timing --assert -j 0 --top-module dcache_tb -f vlog.f -o sim_dcache
./obj_dir/sim_dcache 2>&1 | tee sim.log

if grep -q "TEST PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* verif/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb
    import cache_cfg_pkg::*;
    import mem_bus_pkg::*;
();

    localparam int          NUM_SETS   = 16;
    localparam logic [31:0] FILL_XOR   = 32'h5a3c_96e1;
    localparam int          WAIT_LIMIT = 2000;

    logic      clk;
    logic      reset;
    logic      cpu_req_valid;
    cpu_req_t  cpu_req;
    logic      cpu_req_ready;
    logic      cpu_resp_valid;
    cpu_resp_t cpu_resp;
    logic      mem_req_valid;
    mem_req_t  mem_req;
    logic      mem_credit;
    logic      mem_resp_valid;
    mem_resp_t mem_resp;
    logic      credit_en;
    int        credits;

    logic [7:0] image [logic [31:0]];  // bytes written by the cpu
    mem_req_t   req_log [$];
    int         seed = 32'h6ad19ef3;

    dcache_top #(.NUM_SETS(NUM_SETS)) i_dut (
        .clk              (clk),
        .reset            (reset),
        .cpu_req_valid_i  (cpu_req_valid),
        .cpu_req_i        (cpu_req),
        .cpu_req_ready_o  (cpu_req_ready),
        .cpu_resp_valid_o (cpu_resp_valid),
        .cpu_resp_o       (cpu_resp),
        .mem_req_valid_o  (mem_req_valid),
        .mem_req_o        (mem_req),
        .mem_credit_i     (mem_credit),
        .mem_resp_valid_i (mem_resp_valid),
        .mem_resp_i       (mem_resp)
    );

    mem_model #(.FILL_XOR(FILL_XOR)) i_mem (
        .clk              (clk),
        .reset            (reset),
        .credit_en_i      (credit_en),
        .mem_req_valid_i  (mem_req_valid),
        .mem_req_i        (mem_req),
        .mem_credit_o     (mem_credit),
        .credits_o        (credits),
        .mem_resp_valid_o (mem_resp_valid),
        .mem_resp_o       (mem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(negedge clk) begin
        if (!reset && mem_req_valid) begin
            req_log.push_back(mem_req);   // issued at the next edge
        end
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check(input string what, input logic [255:0] got, input logic [255:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("MISMATCH at time %0t: %s, got %0h expected %0h",
                                        $time, what, got, exp));
        end
    endtask

    function automatic word_t image_word(input logic [31:0] addr);
        logic [31:0] base;
        logic [31:0] dflt;
        word_t       w;
        base = {addr[31:2], 2'b00};
        dflt = base ^ FILL_XOR;   // untouched memory
        for (int b = 0; b < 4; b++) begin
            if (image.exists(base + 32'(b))) begin
                w[8*b +: 8] = image[base + 32'(b)];
            end else begin
                w[8*b +: 8] = dflt[8*b +: 8];
            end
        end
        return w;
    endfunction

    function automatic line_t image_line(input logic [31:0] addr);
        line_t l;
        for (int i = 0; i < LINE_WORDS; i++) begin
            l[i] = image_word({addr[31:5], 5'b00000} + 32'(4 * i));
        end
        return l;
    endfunction

    task automatic image_write(input logic [31:0] addr, input word_t data, input logic [3:0] strb);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                image[{addr[31:2], 2'b00} + 32'(b)] = data[8*b +: 8];
            end
        end
    endtask

    task automatic send_req(input logic wr, input logic unc, input logic [31:0] addr,
                            input word_t wdata, input logic [3:0] strb);
        int t;
        @(posedge clk);
        cpu_req_valid    <= 1'b1;
        cpu_req.write    <= wr;
        cpu_req.uncached <= unc;
        cpu_req.addr     <= addr;
        cpu_req.wdata    <= wdata;
        cpu_req.strb     <= strb;
        t = 0;
        @(negedge clk);
        while (!cpu_req_ready) begin
            t++;
            if (t > WAIT_LIMIT) begin
                stop_with_failure("cpu request was never accepted");
            end
            @(negedge clk);
        end
        @(posedge clk);
        cpu_req_valid <= 1'b0;
    endtask

    task automatic wait_resp(output word_t rdata, output logic miss);
        int t;
        t = 0;
        @(negedge clk);
        while (!cpu_resp_valid) begin
            t++;
            if (t > WAIT_LIMIT) begin
                stop_with_failure("no cpu response arrived");
            end
            @(negedge clk);
        end
        rdata = cpu_resp.rdata;
        miss  = cpu_resp.miss;
    endtask

    task automatic do_read(input logic [31:0] addr, input logic unc, output logic miss);
        word_t got;
        send_req(1'b0, unc, addr, '0, 4'h0);
        wait_resp(got, miss);
        check($sformatf("read data at %h", addr), 256'(got), 256'(image_word(addr)));
    endtask

    task automatic do_write(input logic [31:0] addr, input logic unc, input word_t data,
                            input logic [3:0] strb, output logic miss);
        word_t got;
        send_req(1'b1, unc, addr, data, strb);
        wait_resp(got, miss);
        check("write response data", 256'(got), 256'(0));
        image_write(addr, data, strb);
    endtask

    task automatic test_read_miss_hit();
        logic miss;
        do_read(32'h0000_1024, 1'b0, miss);
        check("miss flag on cold read", 256'(miss), 256'(1));
        do_read(32'h0000_1024, 1'b0, miss);
        check("miss flag on repeated read", 256'(miss), 256'(0));
    endtask

    task automatic test_strobed_write();
        logic miss;
        do_write(32'h0000_1028, 1'b0, 32'hdead_beef, 4'b0101, miss);
        check("miss flag on write hit", 256'(miss), 256'(0));
        do_read(32'h0000_1028, 1'b0, miss);
        check("miss flag on read after write", 256'(miss), 256'(0));
    endtask

    // three lines of set 5
    task automatic test_dirty_eviction();
        logic        miss;
        line_t       b_line;
        logic [31:0] a_addr;
        logic [31:0] b_addr;
        logic [31:0] c_addr;
        a_addr = 32'h0002_00a0;
        b_addr = 32'h0002_02a4;
        c_addr = 32'h0002_04a8;
        do_write(a_addr, 1'b0, 32'h1111_aaaa, 4'hf, miss);
        do_write(b_addr, 1'b0, 32'h2222_bbbb, 4'b1100, miss);
        do_read(a_addr, 1'b0, miss);   // b becomes lru
        check("miss flag on touch of a", 256'(miss), 256'(0));
        b_line = image_line(b_addr);
        req_log.delete();
        do_read(c_addr, 1'b0, miss);
        check("request count on eviction", 256'(req_log.size()), 256'(2));
        check("writeback op", 256'(req_log[0].op), 256'(MEM_WRITE_LINE));
        check("writeback address", 256'(req_log[0].addr), 256'({b_addr[31:5], 5'b00000}));
        check("writeback data", 256'(req_log[0].data), 256'(b_line));
        check("refill op", 256'(req_log[1].op), 256'(MEM_READ_LINE));
        check("refill address", 256'(req_log[1].addr), 256'({c_addr[31:5], 5'b00000}));
        do_read(b_addr, 1'b0, miss);
        check("miss flag on evicted line", 256'(miss), 256'(1));
    endtask

    task automatic test_uncached();
        logic        miss;
        logic [31:0] u_addr;
        u_addr = 32'h0003_0104;
        req_log.delete();
        do_write(u_addr, 1'b1, 32'h1234_5678, 4'b0110, miss);
        do_read(u_addr, 1'b1, miss);
        check("uncached request count", 256'(req_log.size()), 256'(2));
        check("word write op", 256'(req_log[0].op), 256'(MEM_WRITE_WORD));
        check("word write address", 256'(req_log[0].addr), 256'(u_addr));
        check("word write data", 256'(req_log[0].data[0]), 256'(32'h1234_5678));
        check("word write strobe", 256'(req_log[0].strb), 256'(4'b0110));
        check("word read op", 256'(req_log[1].op), 256'(MEM_READ_WORD));
        check("word read address", 256'(req_log[1].addr), 256'(u_addr));
        req_log.delete();
        do_read(u_addr, 1'b0, miss);
        check("miss flag on cached read", 256'(miss), 256'(1));
        check("line read op", 256'(req_log[0].op), 256'(MEM_READ_LINE));
    endtask

    task automatic test_credit_stall();
        logic        miss;
        word_t       got;
        int          k;
        logic [31:0] e_addr;
        e_addr = 32'h0006_0040;
        @(posedge clk);
        credit_en <= 1'b0;
        repeat (3) @(negedge clk);
        k = 0;
        // use up what the cache still holds
        while (credits != 0) begin
            if (k > 16) begin
                stop_with_failure("memory credits did not drain");
            end
            do_write(32'h0005_0000 + 32'(4 * k), 1'b1, 32'hc0de_0000 ^ 32'(k), 4'hf, miss);
            k++;
        end
        send_req(1'b0, 1'b0, e_addr, '0, 4'h0);
        repeat (50) begin
            @(negedge clk);
            check("memory request without credit", 256'(mem_req_valid), 256'(0));
        end
        @(posedge clk);
        credit_en <= 1'b1;
        wait_resp(got, miss);
        check("read data after stall", 256'(got), 256'(image_word(e_addr)));
        check("miss flag after stall", 256'(miss), 256'(1));
    endtask

    // twelve lines, three per set over sets 9 to 12
    task automatic test_random();
        logic [31:0] r;
        logic [31:0] data;
        logic [31:0] addr;
        logic        miss;
        int          sel;
        int          set;
        int          tag;
        int          wsel;
        for (int n = 0; n < 40; n++) begin
            r    = $random(seed);
            data = $random(seed);
            sel  = int'(r % 12);
            set  = 9 + sel % 4;
            tag  = sel / 4;
            wsel = int'(r[10:8]);
            addr = 32'h0010_0000 + 32'(tag * 512 + set * 32 + wsel * 4);
            if (r[16]) begin
                do_write(addr, 1'b0, data, r[23:20], miss);
            end else begin
                do_read(addr, 1'b0, miss);
            end
        end
    endtask

    task automatic test_back_to_back();
        logic [31:0] addrs [4];
        logic        miss;
        addrs[0] = 32'h0020_01a0;
        addrs[1] = 32'h0020_03a0;
        addrs[2] = 32'h0020_01c4;
        addrs[3] = 32'h0020_03c8;
        for (int i = 0; i < 4; i++) begin
            do_read(addrs[i], 1'b0, miss);
        end
        // response for request i shows up one cycle after its accept
        for (int i = 0; i <= 4; i++) begin
            @(posedge clk);
            if (i < 4) begin
                cpu_req_valid <= 1'b1;
                cpu_req.write <= 1'b0;
                cpu_req.uncached <= 1'b0;
                cpu_req.addr  <= addrs[i];
                cpu_req.wdata <= '0;
                cpu_req.strb  <= 4'h0;
            end else begin
                cpu_req_valid <= 1'b0;
            end
            @(negedge clk);
            if (i < 4) begin
                check("ready during hit stream", 256'(cpu_req_ready), 256'(1));
            end
            if (i > 0) begin
                check("hit response valid", 256'(cpu_resp_valid), 256'(1));
                check("hit response data", 256'(cpu_resp.rdata), 256'(image_word(addrs[i-1])));
                check("hit response miss flag", 256'(cpu_resp.miss), 256'(0));
            end
        end
    endtask

    initial begin
        reset         = 1'b1;
        cpu_req_valid = 1'b0;
        cpu_req       = '0;
        credit_en     = 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check("ready after reset", 256'(cpu_req_ready), 256'(1));
        check("response valid after reset", 256'(cpu_resp_valid), 256'(0));
        check("memory request after reset", 256'(mem_req_valid), 256'(0));

        test_read_miss_hit();
        test_strobed_write();
        test_dirty_eviction();
        test_uncached();
        test_credit_stall();
        test_random();
        test_back_to_back();

        $display("TEST PASS");
        $finish;
    end

endmodule

/* verif/mem_model.sv */
`timescale 1ns/1ps

module mem_model
    import cache_cfg_pkg::*;
    import mem_bus_pkg::*;
#(
    parameter logic [31:0] FILL_XOR    = 32'h0,
    parameter int          MAX_CREDITS = 4
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      credit_en_i,
    input  logic      mem_req_valid_i,
    input  mem_req_t  mem_req_i,
    output logic      mem_credit_o,
    output int        credits_o,
    output logic      mem_resp_valid_o,
    output mem_resp_t mem_resp_o
);

    line_t store [tag_t];   // only lines written so far
    line_t resp_q [$];
    int    seed = 32'h6ad19ef3;
    int    owed;            // credits granted and not yet used
    int    gap;
    int    delay;

    function automatic line_t fresh_line(input tag_t lnum);
        line_t l;
        for (int i = 0; i < LINE_WORDS; i++) begin
            l[i] = ({lnum, {OFFSET_W{1'b0}}} + 32'(4 * i)) ^ FILL_XOR;
        end
        return l;
    endfunction

    function automatic line_t read_line(input tag_t lnum);
        return store.exists(lnum) ? store[lnum] : fresh_line(lnum);
    endfunction

    always @(posedge clk) begin : serve
        tag_t       lnum;
        logic [2:0] wsel;
        line_t      line;
        line_t      out_line;
        if (reset) begin
            mem_credit_o     <= 1'b0;
            mem_resp_valid_o <= 1'b0;
            mem_resp_o       <= '0;
            credits_o        <= 0;
            owed = 0;
            gap = 0;
            delay = 0;
            resp_q.delete();
        end else begin
            if (mem_req_valid_i) begin
                lnum = mem_req_i.addr[ADDR_W-1:OFFSET_W];
                wsel = mem_req_i.addr[OFFSET_W-1:2];
                line = read_line(lnum);
                if (resp_q.size() == 0) begin
                    delay = 2 + int'($unsigned($random(seed)) % 8);
                end
                case (mem_req_i.op)
                    MEM_WRITE_LINE: store[lnum] = mem_req_i.data;
                    MEM_READ_LINE:  resp_q.push_back(line);
                    MEM_WRITE_WORD: begin
                        for (int b = 0; b < WORD_BYTES; b++) begin
                            if (mem_req_i.strb[b]) begin
                                line[wsel][8*b +: 8] = mem_req_i.data[0][8*b +: 8];
                            end
                        end
                        store[lnum] = line;
                    end
                    default: begin
                        out_line = '0;
                        out_line[0] = line[wsel];   // word reads come back in word 0
                        resp_q.push_back(out_line);
                    end
                endcase
            end

            mem_resp_valid_o <= 1'b0;
            if (delay > 0) begin
                delay--;
            end else if (resp_q.size() > 0 && !mem_resp_valid_o) begin
                out_line = resp_q.pop_front();
                mem_resp_o.data  <= out_line;
                mem_resp_valid_o <= 1'b1;
                delay = 1 + int'($unsigned($random(seed)) % 8);
            end

            // one pulse is one slot
            owed = owed + int'(mem_credit_o) - int'(mem_req_valid_i);
            mem_credit_o <= 1'b0;
            if (gap > 0) begin
                gap--;
            end else if (credit_en_i && owed < MAX_CREDITS) begin
                mem_credit_o <= 1'b1;
                gap = int'($unsigned($random(seed)) % 6);
            end
            credits_o <= owed;
        end
    end

endmodule

/* design/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top
    import cache_cfg_pkg::*;
    import mem_bus_pkg::*;
#(
    parameter int  NUM_SETS = 128,
    localparam int IDX_W    = $clog2(NUM_SETS)
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      cpu_req_valid_i,
    input  cpu_req_t  cpu_req_i,
    output logic      cpu_req_ready_o,
    output logic      cpu_resp_valid_o,
    output cpu_resp_t cpu_resp_o,
    output logic      mem_req_valid_o,
    output mem_req_t  mem_req_o,
    input  logic      mem_credit_i,
    input  logic      mem_resp_valid_i,
    input  mem_resp_t mem_resp_i
);

    logic [IDX_W-1:0]     data_raddr, data_waddr;
    logic [IDX_W-1:0]     tag_raddr, tag_waddr;
    logic [NUM_WAYS-1:0]  data_we, tag_we;
    line_t                data_wdata;
    tag_t                 tag_wdata;
    line_t [NUM_WAYS-1:0] data_rdata;
    tag_t [NUM_WAYS-1:0]  tag_rdata;

    logic [IDX_W-1:0]     meta_set;
    logic [NUM_WAYS-1:0]  meta_valid, meta_dirty;
    logic                 meta_victim;
    logic                 meta_touch, meta_touch_way;
    logic                 meta_fill, meta_fill_way;
    logic                 meta_mark_dirty;

    dcache_ctrl #(.NUM_SETS(NUM_SETS)) i_ctrl (
        .clk               (clk),
        .reset             (reset),
        .cpu_req_valid_i   (cpu_req_valid_i),
        .cpu_req_i         (cpu_req_i),
        .cpu_req_ready_o   (cpu_req_ready_o),
        .cpu_resp_valid_o  (cpu_resp_valid_o),
        .cpu_resp_o        (cpu_resp_o),
        .mem_req_valid_o   (mem_req_valid_o),
        .mem_req_o         (mem_req_o),
        .mem_credit_i      (mem_credit_i),
        .mem_resp_valid_i  (mem_resp_valid_i),
        .mem_resp_i        (mem_resp_i),
        .data_raddr_o      (data_raddr),
        .data_waddr_o      (data_waddr),
        .data_we_o         (data_we),
        .data_wdata_o      (data_wdata),
        .data_rdata_i      (data_rdata),
        .tag_raddr_o       (tag_raddr),
        .tag_waddr_o       (tag_waddr),
        .tag_we_o          (tag_we),
        .tag_wdata_o       (tag_wdata),
        .tag_rdata_i       (tag_rdata),
        .meta_set_o        (meta_set),
        .meta_valid_i      (meta_valid),
        .meta_dirty_i      (meta_dirty),
        .meta_victim_i     (meta_victim),
        .meta_touch_o      (meta_touch),
        .meta_touch_way_o  (meta_touch_way),
        .meta_fill_o       (meta_fill),
        .meta_fill_way_o   (meta_fill_way),
        .meta_mark_dirty_o (meta_mark_dirty)
    );

    dcache_meta #(.NUM_SETS(NUM_SETS)) i_meta (
        .clk          (clk),
        .reset        (reset),
        .set_i        (meta_set),
        .valid_o      (meta_valid),
        .dirty_o      (meta_dirty),
        .victim_way_o (meta_victim),
        .touch_i      (meta_touch),
        .touch_way_i  (meta_touch_way),
        .fill_i       (meta_fill),
        .fill_way_i   (meta_fill_way),
        .mark_dirty_i (meta_mark_dirty)
    );

    // one data RAM and one tag RAM per way
    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        sdp_ram #(.DEPTH(NUM_SETS), .entry_t(line_t)) i_data (
            .clk     (clk),
            .we_i    (data_we[w]),
            .waddr_i (data_waddr),
            .wdata_i (data_wdata),
            .raddr_i (data_raddr),
            .rdata_o (data_rdata[w])
        );

        sdp_ram #(.DEPTH(NUM_SETS), .entry_t(tag_t)) i_tag (
            .clk     (clk),
            .we_i    (tag_we[w]),
            .waddr_i (tag_waddr),
            .wdata_i (tag_wdata),
            .raddr_i (tag_raddr),
            .rdata_o (tag_rdata[w])
        );
    end

endmodule

/* design/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl
    import cache_cfg_pkg::*;
    import mem_bus_pkg::*;
#(
    parameter int  NUM_SETS = 128,
    localparam int IDX_W    = $clog2(NUM_SETS)
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       cpu_req_valid_i,
    input  cpu_req_t                   cpu_req_i,
    output logic                       cpu_req_ready_o,
    output logic                       cpu_resp_valid_o,
    output cpu_resp_t                  cpu_resp_o,
    output logic                       mem_req_valid_o,
    output mem_req_t                   mem_req_o,
    input  logic                       mem_credit_i,
    input  logic                       mem_resp_valid_i,
    input  mem_resp_t                  mem_resp_i,
    output logic [IDX_W-1:0]           data_raddr_o,
    output logic [IDX_W-1:0]           data_waddr_o,
    output logic [NUM_WAYS-1:0]        data_we_o,
    output line_t                      data_wdata_o,
    input  line_t [NUM_WAYS-1:0]       data_rdata_i,
    output logic [IDX_W-1:0]           tag_raddr_o,
    output logic [IDX_W-1:0]           tag_waddr_o,
    output logic [NUM_WAYS-1:0]        tag_we_o,
    output tag_t                       tag_wdata_o,
    input  tag_t [NUM_WAYS-1:0]        tag_rdata_i,
    output logic [IDX_W-1:0]           meta_set_o,
    input  logic [NUM_WAYS-1:0]        meta_valid_i,
    input  logic [NUM_WAYS-1:0]        meta_dirty_i,
    input  logic                       meta_victim_i,
    output logic                       meta_touch_o,
    output logic                       meta_touch_way_o,
    output logic                       meta_fill_o,
    output logic                       meta_fill_way_o,
    output logic                       meta_mark_dirty_o
);

    localparam int CREDIT_W = 8;
    localparam int WSEL_W   = OFFSET_W - BYTE_OFF_W;

    typedef enum logic [2:0] {
        IDLE, WRITEBACK, REFILL_REQ, REFILL_WAIT, FILL, WORD_REQ, WORD_WAIT, RESP
    } state_e;

    state_e              state_q, state_d;
    logic                lk_valid_q;
    cpu_req_t            lk_req_q;
    line_t               rsp_line_q;
    logic [CREDIT_W-1:0] credit_q;

    logic [IDX_W-1:0]    lk_idx;
    tag_t                lk_tag;
    logic [WSEL_W-1:0]   lk_word;
    logic [NUM_WAYS-1:0] hit;
    logic                hit_way;
    line_t               hit_line;
    logic                cached_hit;
    logic                raw_hazard;
    logic                accept;
    logic                mem_issue;

    function automatic line_t merge_store(line_t line, cpu_req_t req);
        line_t             merged;
        logic [WSEL_W-1:0] w;
        merged = line;
        w      = req.addr[OFFSET_W-1:BYTE_OFF_W];
        if (req.write) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (req.strb[b]) begin
                    merged[w][8*b +: 8] = req.wdata[8*b +: 8];
                end
            end
        end
        return merged;
    endfunction

    assign lk_idx  = lk_req_q.addr[OFFSET_W +: IDX_W];
    assign lk_tag  = lk_req_q.addr[ADDR_W-1:OFFSET_W];
    assign lk_word = lk_req_q.addr[OFFSET_W-1:BYTE_OFF_W];

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_cmp
        assign hit[w] = meta_valid_i[w] && (tag_rdata_i[w] == lk_tag);
    end

    assign hit_way    = hit[1];
    assign hit_line   = data_rdata_i[hit_way];
    assign cached_hit = lk_valid_q && !lk_req_q.uncached && (|hit);

    // next access to a set being written must wait for the RAM write
    assign raw_hazard = cached_hit && lk_req_q.write
                        && (cpu_req_i.addr[OFFSET_W +: IDX_W] == lk_idx);

    assign cpu_req_ready_o = (state_q == IDLE) && (!lk_valid_q || cached_hit) && !raw_hazard;
    assign accept          = cpu_req_valid_i && cpu_req_ready_o;

    // hold the lookup set while stalled so the victim line stays visible
    assign data_raddr_o = cpu_req_ready_o ? cpu_req_i.addr[OFFSET_W +: IDX_W] : lk_idx;
    assign tag_raddr_o  = data_raddr_o;
    assign data_waddr_o = lk_idx;
    assign tag_waddr_o  = lk_idx;

    assign meta_set_o        = lk_idx;
    assign meta_touch_o      = (state_q == IDLE) && cached_hit;
    assign meta_touch_way_o  = hit_way;
    assign meta_fill_o       = (state_q == FILL);
    assign meta_fill_way_o   = meta_victim_i;
    assign meta_mark_dirty_o = lk_req_q.write;

    always_comb begin
        data_we_o    = '0;
        tag_we_o     = '0;
        data_wdata_o = merge_store(hit_line, lk_req_q);
        tag_wdata_o  = lk_tag;
        if (state_q == IDLE && cached_hit && lk_req_q.write) begin
            data_we_o[hit_way] = 1'b1;
        end
        if (state_q == FILL) begin
            data_wdata_o             = merge_store(rsp_line_q, lk_req_q);  // write-allocate
            data_we_o[meta_victim_i] = 1'b1;
            tag_we_o[meta_victim_i]  = 1'b1;
        end
    end

    assign cpu_resp_valid_o = ((state_q == IDLE) && cached_hit) || (state_q == RESP);

    always_comb begin
        cpu_resp_o.miss  = (state_q == RESP);
        cpu_resp_o.rdata = '0;
        if (!lk_req_q.write) begin
            if (state_q != RESP) begin
                cpu_resp_o.rdata = hit_line[lk_word];
            end else if (lk_req_q.uncached) begin
                cpu_resp_o.rdata = rsp_line_q[0];
            end else begin
                cpu_resp_o.rdata = rsp_line_q[lk_word];
            end
        end
    end

    assign mem_req_valid_o = (credit_q != '0) && (state_q inside {WRITEBACK, REFILL_REQ, WORD_REQ});
    assign mem_issue       = mem_req_valid_o;   // no ready, a credit is a slot

    always_comb begin
        mem_req_o.op   = MEM_READ_LINE;
        mem_req_o.addr = {lk_tag, {OFFSET_W{1'b0}}};
        mem_req_o.data = '0;
        mem_req_o.strb = '1;
        if (state_q == WRITEBACK) begin
            mem_req_o.op   = MEM_WRITE_LINE;
            mem_req_o.addr = {tag_rdata_i[meta_victim_i], {OFFSET_W{1'b0}}};
            mem_req_o.data = data_rdata_i[meta_victim_i];
        end else if (state_q == WORD_REQ) begin
            mem_req_o.op      = lk_req_q.write ? MEM_WRITE_WORD : MEM_READ_WORD;
            mem_req_o.addr    = lk_req_q.addr;
            mem_req_o.data[0] = lk_req_q.wdata;
            mem_req_o.strb    = lk_req_q.strb;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (lk_valid_q && !cached_hit) begin
                    if (lk_req_q.uncached) begin
                        state_d = WORD_REQ;
                    end else if (meta_dirty_i[meta_victim_i]) begin
                        state_d = WRITEBACK;
                    end else begin
                        state_d = REFILL_REQ;
                    end
                end
            end
            WRITEBACK:   if (mem_issue) state_d = REFILL_REQ;
            REFILL_REQ:  if (mem_issue) state_d = REFILL_WAIT;
            REFILL_WAIT: if (mem_resp_valid_i) state_d = FILL;
            FILL:        state_d = RESP;
            WORD_REQ: begin
                if (mem_issue) begin
                    state_d = lk_req_q.write ? RESP : WORD_WAIT;    // word writes get no answer
                end
            end
            WORD_WAIT:   if (mem_resp_valid_i) state_d = RESP;
            RESP:        state_d = IDLE;
            default:     state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q    <= IDLE;
            lk_valid_q <= 1'b0;
            credit_q   <= '0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                lk_valid_q <= 1'b1;
            end else if (cpu_resp_valid_o) begin
                lk_valid_q <= 1'b0;
            end
            // saturate, extra grants are dropped
            if (mem_credit_i && !mem_issue && credit_q != '1) begin
                credit_q <= credit_q + 1'b1;
            end else if (!mem_credit_i && mem_issue) begin
                credit_q <= credit_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            lk_req_q <= cpu_req_i;
        end
        if (mem_resp_valid_i) begin
            rsp_line_q <= mem_resp_i.data;
        end
    end

    // every issued request uses up exactly one credit
    a_credit_consumed: assert property (
        @(posedge clk) disable iff (reset)
        mem_issue |=> credit_q == $past(credit_q) + CREDIT_W'($past(mem_credit_i)) - 1'b1
    );

    a_single_hit_way: assert property (
        @(posedge clk) disable iff (reset) lk_valid_q |-> !(&hit)
    );

endmodule

/* design/dcache_meta.sv */
`timescale 1ns/1ps

module dcache_meta
    import cache_cfg_pkg::*;
#(
    parameter int  NUM_SETS = 128,
    localparam int IDX_W    = $clog2(NUM_SETS)
) (
    input  logic                clk,
    input  logic                reset,
    input  logic [IDX_W-1:0]    set_i,
    output logic [NUM_WAYS-1:0] valid_o,
    output logic [NUM_WAYS-1:0] dirty_o,
    output logic                victim_way_o,
    input  logic                touch_i,
    input  logic                touch_way_i,
    input  logic                fill_i,
    input  logic                fill_way_i,
    input  logic                mark_dirty_i
);

    logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_q;
    logic [NUM_SETS-1:0][NUM_WAYS-1:0] dirty_q;
    logic [NUM_SETS-1:0]               lru_q;    // least recently used way

    assign valid_o = valid_q[set_i];
    assign dirty_o = dirty_q[set_i];

    // empty way first
    always_comb begin
        if (!valid_o[0]) begin
            victim_way_o = 1'b0;
        end else if (!valid_o[1]) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = lru_q[set_i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            if (touch_i) begin
                lru_q[set_i] <= !touch_way_i;
                if (mark_dirty_i) begin
                    dirty_q[set_i][touch_way_i] <= 1'b1;   // store hit
                end
            end
            if (fill_i) begin
                valid_q[set_i][fill_way_i] <= 1'b1;
                dirty_q[set_i][fill_way_i] <= mark_dirty_i;
                lru_q[set_i]               <= !fill_way_i;
            end
        end
    end

    a_touch_fill_excl: assert property (
        @(posedge clk) disable iff (reset) !(touch_i && fill_i)
    );

endmodule

/* design/sdp_ram.sv */
`timescale 1ns/1ps

module sdp_ram #(
    parameter int  DEPTH   = 128,
    parameter type entry_t = logic [31:0],
    localparam int AW      = $clog2(DEPTH)
) (
    input  logic          clk,
    input  logic          we_i,
    input  logic [AW-1:0] waddr_i,
    input  entry_t        wdata_i,
    input  logic [AW-1:0] raddr_i,
    output entry_t        rdata_o
);

    entry_t mem_q [DEPTH];

    // read-before-write on a shared entry
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
        rdata_o <= mem_q[raddr_i];
    end

    a_waddr_known: assert property (
        @(posedge clk) we_i |-> !$isunknown(waddr_i)
    );

endmodule

/* design/mem_bus_pkg.sv */
package mem_bus_pkg;

    import cache_cfg_pkg::*;

    typedef struct packed {
        logic                  write;
        logic                  uncached;
        logic [ADDR_W-1:0]     addr;
        word_t                 wdata;
        logic [WORD_BYTES-1:0] strb;
    } cpu_req_t;

    typedef struct packed {
        word_t rdata;   // zero for writes
        logic  miss;
    } cpu_resp_t;

    typedef enum logic [1:0] {
        MEM_READ_LINE,
        MEM_WRITE_LINE,
        MEM_READ_WORD,
        MEM_WRITE_WORD
    } mem_op_e;

    // word write carries its data in word 0
    typedef struct packed {
        mem_op_e               op;
        logic [ADDR_W-1:0]     addr;
        line_t                 data;
        logic [WORD_BYTES-1:0] strb;
    } mem_req_t;

    typedef struct packed {
        line_t data;    // word read returns in word 0
    } mem_resp_t;

endpackage

/* design/cache_cfg_pkg.sv */
package cache_cfg_pkg;

    localparam int ADDR_W     = 32;
    localparam int WORD_BYTES = 4;
    localparam int WORD_W     = 8 * WORD_BYTES;
    localparam int LINE_WORDS = 8;
    localparam int BYTE_OFF_W = $clog2(WORD_BYTES);
    localparam int OFFSET_W   = $clog2(LINE_WORDS * WORD_BYTES);   // 5 bits
    localparam int NUM_WAYS   = 2;

    // full line number, independent of set count
    localparam int TAG_W = ADDR_W - OFFSET_W;

    typedef logic [WORD_W-1:0] word_t;

    // word 0 sits in the low bits
    typedef word_t [LINE_WORDS-1:0] line_t;

    typedef logic [TAG_W-1:0] tag_t;

endpackage
